/* sim.f */
+incdir+bench
common/fetch_pkg.sv
hw/prio_sel.sv
fe_buf/fe_fb_entry.sv
fe_buf/fe_pf.sv
fe_buf/fe_buf.sv
hw/fetch_top.sv
bench/ic_model.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module fetch_tb -o fetch_tb

# Exit status of the run is not used, the log decides
./obj_dir/fetch_tb 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* bench/mem_word.svh */
// Fixed scramble of a byte address, the memory image behind the cache
function automatic t_instr mem_word(t_paddr a);
    t_instr h;
    h = a * 32'h9e37_79b1;
    h = h ^ {a[15:0], a[31:16]};
    return h ^ 32'h1357_9bdf;
endfunction

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam int NUM_SETS = 8;
    localparam int NUM_ENTS = 4;
    localparam int TIMEOUT  = 100;

    logic    clk    = 1'b0;
    logic    rst    = 1'b1;
    t_fe_req fe_req = '0;
    t_fe_rsp fe_rsp;
    t_ic_req ic_req;
    t_ic_rsp ic_rsp;

    integer             seed    = 16936;
    int                 cyc     = 0;
    int                 req_cyc = 0;
    int                 rsp_cyc = 0;
    int                 rsp_cnt = 0;
    logic [FE_ID_W-1:0] next_id = '0;
    t_fe_rsp            exp_q [$];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    fetch_top #(
        .NUM_SETS (NUM_SETS),
        .NUM_ENTS (NUM_ENTS)
    ) u_dut (
        .clk    (clk),
        .rst    (rst),
        .fe_req (fe_req),
        .fe_rsp (fe_rsp),
        .ic_req (ic_req),
        .ic_rsp (ic_rsp)
    );

    ic_model u_ic (
        .clk    (clk),
        .rst    (rst),
        .ic_req (ic_req),
        .ic_rsp (ic_rsp)
    );

    `include "mem_word.svh"

    // Expected instruction with the byte offset dropped
    function automatic t_instr expected_instr(t_paddr a);
        return mem_word({a[ADDR_W-1:2], 2'b00});
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    // One demand request and the wait for its response
    task automatic issue(input t_paddr addr);
        t_fe_rsp want;
        int      start;
        int      waited;
        @(negedge clk);
        fe_req.valid = 1'b1;
        fe_req.id    = next_id;
        fe_req.addr  = addr;
        want.valid   = 1'b1;
        want.id      = next_id;
        want.instr   = expected_instr(addr);
        exp_q.push_back(want);
        next_id = next_id + 1'b1;
        start   = rsp_cnt;
        req_cyc = cyc;
        @(negedge clk);
        fe_req.valid = 1'b0;
        waited = 0;
        while (rsp_cnt == start && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rsp_cnt == start) begin
            fail_run($sformatf("Timeout waiting for the response to address %h", addr));
        end
    endtask

    // A buffer hit answers on the next clock
    task automatic check_hit();
        assert (rsp_cyc - req_cyc == 1)
            else fail_run($sformatf("Mismatch response latency: got %h expected %h",
                                    rsp_cyc - req_cyc, 1));
    endtask

    always @(negedge clk) begin : check_rsp
        t_fe_rsp want;
        if (!rst && fe_rsp.valid) begin
            assert (exp_q.size() > 0)
                else fail_run("Fetch response arrived with no request outstanding");
            want = exp_q.pop_front();
            assert (fe_rsp.id == want.id)
                else fail_run($sformatf("Mismatch fe_rsp.id: got %h expected %h",
                                        fe_rsp.id, want.id));
            assert (fe_rsp.instr == want.instr)
                else fail_run($sformatf("Mismatch fe_rsp.instr: got %h expected %h",
                                        fe_rsp.instr, want.instr));
            rsp_cyc = cyc;
            rsp_cnt = rsp_cnt + 1;
        end
    end

    initial begin : stimulus
        t_paddr a;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet outputs after reset
        repeat (5) begin
            @(negedge clk);
            assert (!fe_rsp.valid && !ic_req.valid)
                else fail_run("Response or cache request active while idle after reset");
        end

        issue(32'h0000_1004);
        issue(32'h0000_100c);
        check_hit();

        // Next line should arrive through the prefetcher
        issue(32'h0000_2008);
        repeat (20) @(negedge clk);
        issue(32'h0000_2014);
        check_hit();

        // Two lines sharing one set
        for (int i = 0; i < 6; i++) begin
            a = (i % 2 == 0) ? 32'h0000_3040 : 32'h0000_30c0;
            issue(a + t_paddr'(4 * (i % 4)));
        end

        for (int i = 0; i < 200; i++) begin
            a = 32'h0000_4000 + (t_paddr'($random(seed)) & 32'h0000_03ff);
            issue(a);
        end

        // Stray late responses still reach the checker here
        repeat (10) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* bench/ic_model.sv */
`timescale 1ns/1ps

module ic_model
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  t_ic_req ic_req,
    output t_ic_rsp ic_rsp
);

    `include "mem_word.svh"

    integer  seed     = 16936;
    int      cyc      = 0;
    int      last_due = 0;
    t_ic_req req_q [$];
    int      due_q [$];
    t_ic_rsp rsp_r    = '0;

    assign ic_rsp = rsp_r;

    // Whole line from memory, word 0 in the low bits
    function automatic t_line line_data(t_paddr base);
        t_line l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*INSTR_W +: INSTR_W] = mem_word(base + t_paddr'(4 * w));
        end
        return l;
    endfunction

    // Requests sampled on the falling edge, answered in order
    always @(negedge clk) begin : serve
        int      lat;
        int      due;
        t_ic_req head;
        if (rst) begin
            req_q.delete();
            due_q.delete();
            rsp_r <= '0;
        end else begin
            cyc = cyc + 1;
            if (ic_req.valid) begin
                lat = 2 + int'($unsigned($random(seed)) % 5);
                due = cyc + lat;
                // Never overtake an older request
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                req_q.push_back(ic_req);
                due_q.push_back(due);
            end
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                head = req_q.pop_front();
                void'(due_q.pop_front());
                rsp_r.valid <= 1'b1;
                rsp_r.id    <= head.id;
                rsp_r.data  <= line_data(head.addr);
            end else begin
                rsp_r <= '0;
            end
        end
    end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int NUM_SETS = 8,
    parameter int NUM_ENTS = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  t_fe_req fe_req,
    output t_fe_rsp fe_rsp,
    output t_ic_req ic_req,
    input  t_ic_rsp ic_rsp
);

    // Fetch buffer between fetch unit and I-cache
    fe_buf #(
        .NUM_SETS (NUM_SETS),
        .NUM_ENTS (NUM_ENTS)
    ) u_fe_buf (
        .clk    (clk),
        .rst    (rst),
        .fe_req (fe_req),
        .fe_rsp (fe_rsp),
        .ic_req (ic_req),
        .ic_rsp (ic_rsp)
    );

endmodule

/* fe_buf/fe_buf.sv */
`timescale 1ns/1ps

module fe_buf
    import fetch_pkg::*;
#(
    parameter int NUM_SETS = 8,
    parameter int NUM_ENTS = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  t_fe_req fe_req,
    output t_fe_rsp fe_rsp,
    output t_ic_req ic_req,
    input  t_ic_rsp ic_rsp
);

    localparam int SET_W  = $clog2(NUM_SETS);
    localparam int ENT_IW = $clog2(NUM_ENTS);
    localparam int CNT_W  = $clog2(NUM_ENTS + 1);

    function automatic logic [SET_W-1:0] set_of(t_paddr a);
        return a[LINE_OFF_W +: SET_W];
    endfunction

    // Line buffer
    logic [NUM_SETS-1:0] buf_valid;
    t_paddr              buf_tag  [NUM_SETS-1:0];
    t_line               buf_data [NUM_SETS-1:0];

    logic [SET_W-1:0]    req_set;
    logic                hit;
    logic                miss;

    // Miss entries
    logic [NUM_ENTS-1:0] ent_valid;
    logic [NUM_ENTS-1:0] ent_push;
    logic [NUM_ENTS-1:0] ent_fill;
    t_ent_static         ent_static [NUM_ENTS-1:0];
    t_ent_static         push_static;
    logic [NUM_ENTS-1:0] free_first;
    logic [CNT_W-1:0]    free_cnt;

    logic [NUM_ENTS-1:0] ic_rq;
    logic [NUM_ENTS-1:0] ic_gnt;
    t_ic_req             ic_pkts [NUM_ENTS-1:0];

    logic [NUM_ENTS-1:0] fe_rq;
    logic [NUM_ENTS-1:0] fe_gnt_raw;
    logic [NUM_ENTS-1:0] fe_gnt;
    t_fe_rsp             fe_pkts [NUM_ENTS-1:0];
    t_fe_rsp             ent_rsp;
    t_fe_rsp             rsp_nxt;

    // Prefetch handshake
    logic                pf_rq;
    t_fe_req             pf_pkt;
    logic                pf_gnt;
    logic                pf_dup;
    logic                pf_room;
    logic                pf_push;

    t_ent_static         fill_ent;
    logic [SET_W-1:0]    fill_set;

    // Lookup
    assign req_set = set_of(fe_req.addr);
    assign hit     = fe_req.valid & buf_valid[req_set] & same_line(buf_tag[req_set], fe_req.addr);
    assign miss    = fe_req.valid & ~hit;

    // Free entries and lines already in flight
    always_comb begin
        pf_dup     = 1'b0;
        free_cnt   = '0;
        free_first = '0;
        for (int i = 0; i < NUM_ENTS; i++) begin
            if (ent_valid[i] && same_line(ent_static[i].req.addr, pf_pkt.addr)) begin
                pf_dup = 1'b1;
            end
            if (!ent_valid[i]) begin
                free_cnt = free_cnt + 1'b1;
                if (free_first == '0) begin
                    free_first[i] = 1'b1;
                end
            end
        end
    end

    // Prefetch keeps one entry spare for a demand miss
    assign pf_room = free_cnt >= CNT_W'(2);
    assign pf_push = pf_rq & ~miss & ~pf_dup & pf_room;
    assign pf_gnt  = pf_rq & ~miss & (pf_dup | pf_room);

    assign ent_push        = (miss | pf_push) ? free_first : '0;
    assign push_static.req = miss ? fe_req : pf_pkt;
    assign push_static.pf  = ~miss;

    for (genvar i = 0; i < NUM_ENTS; i++) begin : g_ent
        assign ent_fill[i] = ic_rsp.valid & (ic_rsp.id == ENT_ID_W'(i));

        fe_fb_entry u_ent (
            .clk         (clk),
            .rst         (rst),
            .push        (ent_push[i]),
            .push_static (push_static),
            .valid       (ent_valid[i]),
            .static_info (ent_static[i]),
            .ic_rq       (ic_rq[i]),
            .ic_gnt      (ic_gnt[i]),
            .fill        (ent_fill[i]),
            .fe_rq       (fe_rq[i]),
            .fe_gnt      (fe_gnt[i])
        );

        assign ic_pkts[i].valid = ic_rq[i];
        assign ic_pkts[i].id    = ENT_ID_W'(i);
        assign ic_pkts[i].addr  = line_addr(ent_static[i].req.addr);

        // Data was written to the buffer on the fill, read it back here
        assign fe_pkts[i].valid = fe_rq[i];
        assign fe_pkts[i].id    = ent_static[i].req.id;
        assign fe_pkts[i].instr = instr_from_line(buf_data[set_of(ent_static[i].req.addr)],
                                                  line_offset(ent_static[i].req.addr));
    end

    prio_sel #(
        .N (NUM_ENTS),
        .T (t_ic_req)
    ) u_ic_sel (
        .rq   (ic_rq),
        .pkts (ic_pkts),
        .gnt  (ic_gnt),
        .sel  (),
        .pkt  (ic_req)
    );

    prio_sel #(
        .N (NUM_ENTS),
        .T (t_fe_rsp)
    ) u_fe_sel (
        .rq   (fe_rq),
        .pkts (fe_pkts),
        .gnt  (fe_gnt_raw),
        .sel  (),
        .pkt  (ent_rsp)
    );

    // A hit takes the response slot, entries wait
    assign fe_gnt = hit ? '0 : fe_gnt_raw;

    always_comb begin
        rsp_nxt = ent_rsp;
        if (hit) begin
            rsp_nxt.valid = 1'b1;
            rsp_nxt.id    = fe_req.id;
            rsp_nxt.instr = instr_from_line(buf_data[req_set], line_offset(fe_req.addr));
        end
    end

    always_ff @(posedge clk) begin
        fe_rsp.id    <= rsp_nxt.id;
        fe_rsp.instr <= rsp_nxt.instr;
        if (rst) begin
            fe_rsp.valid <= 1'b0;
        end else begin
            fe_rsp.valid <= rsp_nxt.valid;
        end
    end

    fe_pf u_pf (
        .clk    (clk),
        .rst    (rst),
        .fe_req (fe_req),
        .pf_rq  (pf_rq),
        .pf_pkt (pf_pkt),
        .pf_gnt (pf_gnt)
    );

    // Fill goes to the set of the entry named by the response
    assign fill_ent = ent_static[ic_rsp.id[ENT_IW-1:0]];
    assign fill_set = set_of(fill_ent.req.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= '0;
        end else if (ic_rsp.valid) begin
            buf_valid[fill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ic_rsp.valid) begin
            buf_tag[fill_set]  <= line_addr(fill_ent.req.addr);
            buf_data[fill_set] <= ic_rsp.data;
        end
    end

    // Relies on the fetch side keeping one demand outstanding
    a_demand_free: assert property (@(posedge clk) disable iff (rst)
        miss |-> (ent_valid != '1));

    a_rsp_owner: assert property (@(posedge clk) disable iff (rst)
        ic_rsp.valid |-> ent_valid[ic_rsp.id[ENT_IW-1:0]]);

endmodule

/* fe_buf/fe_pf.sv */
`timescale 1ns/1ps

module fe_pf
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  t_fe_req fe_req,
    output logic    pf_rq,
    output t_fe_req pf_pkt,
    input  logic    pf_gnt
);

    t_paddr pf_addr;

    // Newest demand request replaces a pending prefetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pf_rq <= 1'b0;
        end else if (fe_req.valid) begin
            pf_rq <= 1'b1;
        end else if (pf_gnt) begin
            pf_rq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fe_req.valid) begin
            pf_addr <= line_addr(fe_req.addr) + ADDR_W'(LINE_BYTES);
        end
    end

    // Id has no meaning for a prefetch
    always_comb begin
        pf_pkt.valid = pf_rq;
        pf_pkt.id    = '0;
        pf_pkt.addr  = pf_addr;
    end

endmodule

/* fe_buf/fe_fb_entry.sv */
`timescale 1ns/1ps

module fe_fb_entry
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  t_ent_static push_static,
    output logic        valid,
    output t_ent_static static_info,
    output logic        ic_rq,
    input  logic        ic_gnt,
    input  logic        fill,
    output logic        fe_rq,
    input  logic        fe_gnt
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } t_state;

    t_state state;
    t_state state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (push) begin
                    state_nxt = ST_REQ;
                end
            end
            ST_REQ: begin
                if (ic_gnt) begin
                    state_nxt = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // Prefetch has nobody to answer
                if (fill) begin
                    state_nxt = static_info.pf ? ST_IDLE : ST_RESP;
                end
            end
            ST_RESP: begin
                if (fe_gnt) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            static_info <= push_static;
        end
    end

    assign valid = state != ST_IDLE;
    assign ic_rq = state == ST_REQ;
    assign fe_rq = state == ST_RESP;

    a_push_idle: assert property (@(posedge clk) disable iff (rst)
        push |-> state == ST_IDLE);

endmodule

/* hw/prio_sel.sv */
`timescale 1ns/1ps

module prio_sel #(
    parameter int  N = 4,
    parameter type T = logic
) (
    input  logic [N-1:0]         rq,
    input  T                     pkts [N-1:0],
    output logic [N-1:0]         gnt,
    output logic [$clog2(N)-1:0] sel,
    output T                     pkt
);

    // Lowest index wins
    always_comb begin
        gnt = '0;
        sel = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (rq[i]) begin
                gnt    = '0;
                gnt[i] = 1'b1;
                sel    = i[$clog2(N)-1:0];
            end
        end
    end

    // Zero payload when nothing requests
    always_comb begin
        if (|rq) begin
            pkt = pkts[sel];
        end else begin
            pkt = '0;
        end
    end

endmodule

/* common/fetch_pkg.sv */
package fetch_pkg;

    localparam int ADDR_W     = 32;
    localparam int INSTR_W    = 32;
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = 128;
    localparam int FE_ID_W    = 4;
    localparam int ENT_ID_W   = 3;

    // Derived line geometry
    localparam int LINE_OFF_W     = $clog2(LINE_BYTES);
    localparam int WORDS_PER_LINE = LINE_W / INSTR_W;
    localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);

    typedef logic [ADDR_W-1:0]     t_paddr;
    typedef logic [LINE_W-1:0]     t_line;
    typedef logic [INSTR_W-1:0]    t_instr;
    typedef logic [WORD_IDX_W-1:0] t_word_idx;

    typedef struct packed {
        logic               valid;
        logic [FE_ID_W-1:0] id;
        t_paddr             addr;
    } t_fe_req;

    typedef struct packed {
        logic               valid;
        logic [FE_ID_W-1:0] id;
        t_instr             instr;
    } t_fe_rsp;

    // Id names the miss entry that issued the request
    typedef struct packed {
        logic                valid;
        logic [ENT_ID_W-1:0] id;
        t_paddr              addr;
    } t_ic_req;

    typedef struct packed {
        logic                valid;
        logic [ENT_ID_W-1:0] id;
        t_line               data;
    } t_ic_rsp;

    typedef struct packed {
        t_fe_req req;
        logic    pf;
    } t_ent_static;

    function automatic t_paddr line_addr(t_paddr a);
        return {a[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    endfunction

    // Word index, byte offset bits dropped
    function automatic t_word_idx line_offset(t_paddr a);
        return a[LINE_OFF_W-1 -: WORD_IDX_W];
    endfunction

    function automatic logic same_line(t_paddr a, t_paddr b);
        return line_addr(a) == line_addr(b);
    endfunction

    // Word 0 sits in the low bits of the line
    function automatic t_instr instr_from_line(t_line l, t_word_idx idx);
        return l[idx*INSTR_W +: INSTR_W];
    endfunction

endpackage
